//--- design/lspExpand_defines.svh
`ifndef LSPEXPAND_DEFINES_SVH
`define LSPEXPAND_DEFINES_SVH

//////////////////////////////////////////////////
// Buffer placement in scratch memory
//////////////////////////////////////////////////

// Address of coefficient 0
`define LSP_BASE 64

// Coefficients per buffer
`define LSP_NC 5

//////////////////////////////////////////////////
// Scratch memory geometry
//////////////////////////////////////////////////

`define MEM_AW 11
`define MEM_DW 32

`endif

//--- design/lspExpandPkg.sv
`include "lspExpand_defines.svh"

package lspExpandPkg;

	//////////////////////////////////////////////////
	// Data types
	//////////////////////////////////////////////////

	// Q15 fractional sample
	typedef logic signed [15:0] word16;

	// Scratch memory address
	typedef logic [`MEM_AW-1:0] memAddr;

	// Scratch memory word, coefficients sign extended
	typedef logic [`MEM_DW-1:0] memData;

	//////////////////////////////////////////////////
	// Controller states
	//////////////////////////////////////////////////

	typedef enum logic [2:0]
	{
		idle,
		readLow,
		readHigh,
		capture,
		compute,
		writeLow,
		writeHigh,
		finish
	} expandState;

endpackage

//--- design/lspBasicOps.sv
`timescale 1ns/1ps

module lspBasicOps
	import lspExpandPkg::*;
(
	input  word16      addA,
	input  word16      addB,
	input  word16      subA,
	input  word16      subB,
	input  word16      shrVal,
	input  logic [3:0] shrAmt,
	output word16      sum,
	output word16      diff,
	output word16      shifted
);

	//////////////////////////////////////////////////
	// Saturating add
	//////////////////////////////////////////////////

	logic signed [16:0] wideSum;
	logic signed [16:0] wideDiff;

	always_comb
	begin
		// One guard bit catches overflow
		wideSum = {addA[15], addA} + {addB[15], addB};
		if (wideSum[16] != wideSum[15])
			// Sign of the wide result picks the rail
			sum = wideSum[16] ? 16'sh8000 : 16'sh7fff;
		else
			sum = wideSum[15:0];
	end

	//////////////////////////////////////////////////
	// Saturating subtract
	//////////////////////////////////////////////////

	always_comb
	begin
		wideDiff = {subA[15], subA} - {subB[15], subB};
		if (wideDiff[16] != wideDiff[15])
			diff = wideDiff[16] ? 16'sh8000 : 16'sh7fff;
		else
			diff = wideDiff[15:0];
	end

	//////////////////////////////////////////////////
	// Arithmetic shift right
	//////////////////////////////////////////////////

	// Sign fills from the left, never overflows
	assign shifted = shrVal >>> shrAmt;

endmodule

//--- design/scratchMemory.sv
`timescale 1ns/1ps

`include "lspExpand_defines.svh"

module scratchMemory
	import lspExpandPkg::*;
(
	input  logic   clk,
	input  memAddr writeAddr,
	input  memData writeData,
	input  logic   writeEn,
	input  memAddr readAddr,
	output memData readData
);

	// Full address space, block RAM style
	memData mem [0:(2**`MEM_AW)-1];

	//////////////////////////////////////////////////
	// Write port A
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (writeEn)
			mem[writeAddr] <= writeData;
	end

	//////////////////////////////////////////////////
	// Read port B
	//////////////////////////////////////////////////

	// Output register gives one cycle of latency
	always_ff @(posedge clk)
	begin
		readData <= mem[readAddr];
	end

endmodule

//--- design/lspExpandFsm.sv
`timescale 1ns/1ps

`include "lspExpand_defines.svh"

module lspExpandFsm
	import lspExpandPkg::*;
(
	input  logic       clk,
	input  logic       arstN,
	input  logic       start,
	input  word16      gap,
	input  memData     readData,
	input  word16      sum,
	input  word16      diff,
	input  word16      shifted,
	output word16      addA,
	output word16      addB,
	output word16      subA,
	output word16      subB,
	output word16      shrVal,
	output logic [3:0] shrAmt,
	output memAddr     readAddr,
	output memAddr     writeAddr,
	output memData     writeData,
	output logic       writeEn,
	output logic       done
);

	expandState state;

	// Upper index j of the current pair
	logic [2:0] pairIdx;

	// Pair words and working values
	word16 lowWord;
	word16 highWord;
	word16 tmp;
	word16 gapReg;

	logic lastPair;

	assign lastPair = (pairIdx == `LSP_NC - 1);

	//////////////////////////////////////////////////
	// State and pair index
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state   <= idle;
			pairIdx <= 3'd1;
		end
		else
		begin
			case (state)
				idle:
				begin
					// Start only counts while idle
					if (start)
					begin
						state   <= readLow;
						pairIdx <= 3'd1;
					end
				end
				readLow:   state <= readHigh;
				readHigh:  state <= capture;
				capture:   state <= compute;
				compute:
				begin
					// Positive tmp means the pair is too close
					if (shifted > 0)
						state <= writeLow;
					else if (lastPair)
						state <= finish;
					else
					begin
						state   <= readLow;
						pairIdx <= pairIdx + 3'd1;
					end
				end
				writeLow:  state <= writeHigh;
				writeHigh:
				begin
					if (lastPair)
						state <= finish;
					else
					begin
						state   <= readLow;
						pairIdx <= pairIdx + 3'd1;
					end
				end
				default:   state <= idle;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Payload registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (state == idle && start)
			gapReg <= gap;
		// Word j-1 arrives one cycle after its address
		if (state == readHigh)
			lowWord <= readData[15:0];
		if (state == capture)
			highWord <= readData[15:0];
		// Half of diff plus gap
		if (state == compute)
			tmp <= shifted;
	end

	//////////////////////////////////////////////////
	// Arithmetic operand select
	//////////////////////////////////////////////////

	always_comb
	begin
		// Compute step chain by default
		subA   = lowWord;
		subB   = highWord;
		addA   = diff;
		addB   = gapReg;
		shrVal = sum;
		shrAmt = 4'd1;
		case (state)
			writeLow:  subB = tmp;
			writeHigh:
			begin
				addA = highWord;
				addB = tmp;
			end
			default: ;
		endcase
	end

	//////////////////////////////////////////////////
	// Memory side
	//////////////////////////////////////////////////

	// Word j-1 on readLow, word j otherwise
	assign readAddr = (state == readLow) ? memAddr'(`LSP_BASE + pairIdx - 1)
	                                     : memAddr'(`LSP_BASE + pairIdx);

	// Lower word moves down, upper word moves up
	assign writeAddr = (state == writeLow) ? memAddr'(`LSP_BASE + pairIdx - 1)
	                                       : memAddr'(`LSP_BASE + pairIdx);
	assign writeData = (state == writeLow) ? {{(`MEM_DW-16){diff[15]}}, diff}
	                                       : {{(`MEM_DW-16){sum[15]}}, sum};

	assign writeEn = (state == writeLow) || (state == writeHigh);

	// Single cycle pulse
	assign done = (state == finish);

endmodule

//--- design/lspExpandPipe.sv
`timescale 1ns/1ps

module lspExpandPipe
	import lspExpandPkg::*;
(
	input  logic                clk,
	input  logic                arstN,
	input  logic                start,
	input  word16               gap,
	input  logic                testMode,
	input  memAddr              testReadAddr,
	input  memAddr              testWriteAddr,
	input  lspExpandPkg::memData testWriteData,
	input  logic                testWriteEn,
	output lspExpandPkg::memData memData,
	output logic                done
);

	// Controller side of the memory
	memAddr               fsmReadAddr;
	memAddr               fsmWriteAddr;
	lspExpandPkg::memData fsmWriteData;
	logic                 fsmWriteEn;

	// Memory side after the muxes
	memAddr               muxReadAddr;
	memAddr               muxWriteAddr;
	lspExpandPkg::memData muxWriteData;
	logic                 muxWriteEn;

	// Arithmetic operands and results
	word16      addA, addB, subA, subB, shrVal;
	logic [3:0] shrAmt;
	word16      sum, diff, shifted;

	//////////////////////////////////////////////////
	// Test port muxes
	//////////////////////////////////////////////////

	always_comb
	begin
		if (testMode)
		begin
			muxReadAddr  = testReadAddr;
			muxWriteAddr = testWriteAddr;
			muxWriteData = testWriteData;
			muxWriteEn   = testWriteEn;
		end
		else
		begin
			// Controller owns the memory during a run
			muxReadAddr  = fsmReadAddr;
			muxWriteAddr = fsmWriteAddr;
			muxWriteData = fsmWriteData;
			muxWriteEn   = fsmWriteEn;
		end
	end

	//////////////////////////////////////////////////
	// Submodules
	//////////////////////////////////////////////////

	scratchMemory testMem (
		.clk      (clk),
		.writeAddr(muxWriteAddr),
		.writeData(muxWriteData),
		.writeEn  (muxWriteEn),
		.readAddr (muxReadAddr),
		.readData (memData)
	);

	lspBasicOps ops (
		.addA   (addA),
		.addB   (addB),
		.subA   (subA),
		.subB   (subB),
		.shrVal (shrVal),
		.shrAmt (shrAmt),
		.sum    (sum),
		.diff   (diff),
		.shifted(shifted)
	);

	lspExpandFsm fsm (
		.clk      (clk),
		.arstN    (arstN),
		.start    (start),
		.gap      (gap),
		.readData (memData),
		.sum      (sum),
		.diff     (diff),
		.shifted  (shifted),
		.addA     (addA),
		.addB     (addB),
		.subA     (subA),
		.subB     (subB),
		.shrVal   (shrVal),
		.shrAmt   (shrAmt),
		.readAddr (fsmReadAddr),
		.writeAddr(fsmWriteAddr),
		.writeData(fsmWriteData),
		.writeEn  (fsmWriteEn),
		.done     (done)
	);

endmodule

//--- test/lspExpandChecker.sv
`timescale 1ns/1ps

`include "lspExpand_defines.svh"

module lspExpandChecker
	import lspExpandPkg::*;
(
	input logic   clk,
	input logic   arstN,
	input logic   start,
	input word16  gap,
	input logic   testMode,
	input memAddr testReadAddr,
	input memAddr testWriteAddr,
	input memData testWriteData,
	input logic   testWriteEn,
	input memData memRead,
	input logic   done
);

	int errorCount = 0;
	int compareCount = 0;

	// Shadow of every word written through the test port
	memData shadow [int];

	logic   busy = 1'b0;
	logic   pendingValid = 1'b0;
	memAddr pendingAddr;
	memData pendingExp;

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	// Clamp to the Q15 range
	function automatic word16 satAdd(input word16 a, input word16 b);
		int r;
		r = int'(a) + int'(b);
		if (r > 32767)
			r = 32767;
		else if (r < -32768)
			r = -32768;
		return word16'(r);
	endfunction

	function automatic word16 satSub(input word16 a, input word16 b);
		int r;
		r = int'(a) - int'(b);
		if (r > 32767)
			r = 32767;
		else if (r < -32768)
			r = -32768;
		return word16'(r);
	endfunction

	function automatic memData widen(input word16 v);
		return memData'({{(`MEM_DW-16){v[15]}}, v});
	endfunction

	task automatic expandShadow(input word16 g);
		int j;
		word16 lo;
		word16 hi;
		word16 t;
		for (j = 1; j < `LSP_NC; j++)
		begin
			// Word j-1 may already hold the previous pair's result
			lo = word16'(shadow[`LSP_BASE + j - 1][15:0]);
			hi = word16'(shadow[`LSP_BASE + j][15:0]);
			t = satAdd(satSub(lo, hi), g) >>> 1;
			if (t > 0)
			begin
				shadow[`LSP_BASE + j - 1] = widen(satSub(lo, t));
				shadow[`LSP_BASE + j] = widen(satAdd(hi, t));
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Input tracking on the rising edge
	//////////////////////////////////////////////////

	always @(posedge clk)
	begin
		// Read sees the old word when read and write share an edge
		pendingValid = testMode && shadow.exists(int'(testReadAddr));
		if (pendingValid)
		begin
			pendingAddr = testReadAddr;
			pendingExp = shadow[int'(testReadAddr)];
		end
		if (testMode && testWriteEn)
			shadow[int'(testWriteAddr)] = testWriteData;
		if (arstN)
		begin
			// Start while busy is ignored, same as the controller
			if (start && !busy)
			begin
				busy = 1'b1;
				expandShadow(gap);
			end
			if (done)
			begin
				if (!busy)
				begin
					$display("Unexpected done pulse with no run in progress at %0t", $time);
					errorCount++;
				end
				busy = 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////
	// Read data compare, between edges
	//////////////////////////////////////////////////

	always @(negedge clk)
	begin
		if (pendingValid)
		begin
			compareCount++;
			if (memRead !== pendingExp)
			begin
				$display("** Error at %0t: memData (address %0d) expected %h, actual %h",
					$time, pendingAddr, pendingExp, memRead);
				errorCount++;
			end
		end
	end

endmodule

//--- test/lspExpand_asserts.sv
`timescale 1ns/1ps

`include "lspExpand_defines.svh"

module lspExpandAsserts
	import lspExpandPkg::*;
(
	input logic   clk,
	input logic   arstN,
	input logic   testMode,
	input logic   done,
	input logic   writeEn,
	input memAddr writeAddr,
	input memAddr readAddr,
	input memData readData
);

	int violations = 0;

	// One flag per word, set once the word has been written
	logic loaded [0:(2**`MEM_AW)-1];
	logic readLoaded;

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < 2**`MEM_AW; i++)
				loaded[i] <= 1'b0;
		end
		else if (writeEn && !$isunknown(writeAddr))
			loaded[writeAddr] <= 1'b1;
	end

	assign readLoaded = loaded[readAddr];

	//////////////////////////////////////////////////
	// Protocol properties
	//////////////////////////////////////////////////

	doneSinglePulse: assert property (@(posedge clk) disable iff (!arstN) done |=> !done)
	else
	begin
		violations++;
		$error("done stayed high for two cycles");
	end

	// Controller writes stay inside the buffer
	writeInBuffer: assert property (@(posedge clk) disable iff (!arstN)
		(!testMode && writeEn) |->
		(writeAddr >= `LSP_BASE && writeAddr <= `LSP_BASE + `LSP_NC - 1))
	else
	begin
		violations++;
		$error("controller wrote outside the buffer at address %0d", writeAddr);
	end

	readKnown: assert property (@(posedge clk) disable iff (!arstN)
		readLoaded |=> !$isunknown(readData))
	else
	begin
		violations++;
		$error("memory returned an unknown word for a loaded address");
	end

endmodule

bind lspExpandPipe lspExpandAsserts asrt (
	.clk      (clk),
	.arstN    (arstN),
	.testMode (testMode),
	.done     (done),
	.writeEn  (muxWriteEn),
	.writeAddr(muxWriteAddr),
	.readAddr (muxReadAddr),
	.readData (memData)
);

//--- test/lspExpandTb.sv
`timescale 1ns/1ps

`include "lspExpand_defines.svh"

module lspExpandTb
	import lspExpandPkg::*;
();

	localparam int numTests = 21;
	// Twice the run, load and readback cycles of each test
	localparam int cycleLimit = numTests * (25 + 14 + 8) * 2;

	logic   clk;
	logic   arstN;
	logic   start;
	word16  gap;
	logic   testMode;
	memAddr testReadAddr;
	memAddr testWriteAddr;
	memData testWriteData;
	logic   testWriteEn;
	memData memRead;
	logic   done;

	word16  coef [0:`LSP_NC-1];
	memData guardBelow;
	memData guardAbove;
	int     cycles = 0;
	int     testNum = 0;
	int     testsPassed = 0;
	int     testsFailed = 0;

	lspExpandPipe uut (
		.clk          (clk),
		.arstN        (arstN),
		.start        (start),
		.gap          (gap),
		.testMode     (testMode),
		.testReadAddr (testReadAddr),
		.testWriteAddr(testWriteAddr),
		.testWriteData(testWriteData),
		.testWriteEn  (testWriteEn),
		.memData      (memRead),
		.done         (done)
	);

	lspExpandChecker chk (
		.clk          (clk),
		.arstN        (arstN),
		.start        (start),
		.gap          (gap),
		.testMode     (testMode),
		.testReadAddr (testReadAddr),
		.testWriteAddr(testWriteAddr),
		.testWriteData(testWriteData),
		.testWriteEn  (testWriteEn),
		.memRead      (memRead),
		.done         (done)
	);

	//////////////////////////////////////////////////
	// Clock and timeout
	//////////////////////////////////////////////////

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= cycleLimit)
		begin
			$display("Run timed out after %0d cycles without finishing", cycles);
			$display("Regression failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic int randRange(input int lo, input int hi);
		return lo + int'($urandom % (hi - lo + 1));
	endfunction

	function automatic int totalErrors();
		return chk.errorCount + uut.asrt.violations;
	endfunction

	// Buffer plus one guard word on each side
	task automatic loadBuffer();
		int k;
		testMode = 1'b1;
		testWriteEn = 1'b1;
		testWriteAddr = memAddr'(`LSP_BASE - 1);
		testWriteData = guardBelow;
		@(negedge clk);
		for (k = 0; k < `LSP_NC; k++)
		begin
			testWriteAddr = memAddr'(`LSP_BASE + k);
			testWriteData = {{(`MEM_DW-16){coef[k][15]}}, coef[k]};
			@(negedge clk);
		end
		testWriteAddr = memAddr'(`LSP_BASE + `LSP_NC);
		testWriteData = guardAbove;
		@(negedge clk);
		testWriteEn = 1'b0;
	endtask

	// Second start pulse after restartAfter cycles when nonzero
	task automatic runExpand(input word16 g, input int restartAfter);
		testMode = 1'b0;
		gap = g;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		if (restartAfter > 0)
		begin
			repeat (restartAfter) @(negedge clk);
			gap = ~g;
			start = 1'b1;
			@(negedge clk);
			start = 1'b0;
		end
		while (!done)
			@(negedge clk);
		@(negedge clk);
	endtask

	task automatic readBack();
		int a;
		testMode = 1'b1;
		for (a = `LSP_BASE - 1; a <= `LSP_BASE + `LSP_NC; a++)
		begin
			testReadAddr = memAddr'(a);
			@(negedge clk);
		end
		// Let the checker see the last word
		repeat (2) @(negedge clk);
	endtask

	task automatic reportTest(input string name, input int errorsBefore, input int comparesBefore);
		int newErrors;
		int newCompares;
		testNum++;
		newErrors = totalErrors() - errorsBefore;
		newCompares = chk.compareCount - comparesBefore;
		if (newCompares < `LSP_NC + 2)
		begin
			$display("Test %0d %s: only %0d words were compared", testNum, name, newCompares);
			newErrors++;
		end
		if (newErrors == 0)
		begin
			testsPassed++;
			$display("Test %0d %s: ok", testNum, name);
		end
		else
		begin
			testsFailed++;
			$display("Test %0d %s: FAILED with %0d errors", testNum, name, newErrors);
		end
	endtask

	//////////////////////////////////////////////////
	// Buffer generators
	//////////////////////////////////////////////////

	// Spacing of at least 20 keeps every tmp at or below zero for gap 10
	task automatic makeAscending();
		int k;
		int v;
		v = randRange(-30000, -10000);
		for (k = 0; k < `LSP_NC; k++)
		begin
			coef[k] = word16'(v);
			v += randRange(20, 2000);
		end
	endtask

	task automatic makeClose();
		int k;
		int v;
		int falling;
		falling = randRange(0, 1);
		v = randRange(-20000, 20000);
		for (k = 0; k < `LSP_NC; k++)
		begin
			coef[k] = word16'(v);
			if (falling)
				v -= randRange(0, 3000);
			else
				v += randRange(0, 15);
		end
	endtask

	task automatic makeExtreme();
		int k;
		int pick [0:7];
		pick = '{32767, 32760, 32700, 32000, -32000, -32700, -32760, -32768};
		for (k = 0; k < `LSP_NC; k++)
			coef[k] = word16'(pick[randRange(0, 7)]);
	endtask

	task automatic makeGuards();
		guardBelow = $urandom;
		guardAbove = $urandom;
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial
	begin
		int errorsBefore;
		int comparesBefore;
		int t;
		// Seed the generator once
		void'($urandom(32'hce1));
		arstN = 1'b0;
		start = 1'b0;
		gap = '0;
		testMode = 1'b0;
		testReadAddr = '0;
		testWriteAddr = '0;
		testWriteData = '0;
		testWriteEn = 1'b0;
		// Three rising edges in reset
		repeat (3) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;
		@(negedge clk);

		errorsBefore = totalErrors();
		comparesBefore = chk.compareCount;
		makeClose();
		makeGuards();
		loadBuffer();
		readBack();
		reportTest("load and readback", errorsBefore, comparesBefore);

		for (t = 0; t < 4; t++)
		begin
			errorsBefore = totalErrors();
			comparesBefore = chk.compareCount;
			makeAscending();
			makeGuards();
			loadBuffer();
			runExpand(16'sd10, 0);
			readBack();
			reportTest("wide ascending, gap 10", errorsBefore, comparesBefore);
		end

		for (t = 0; t < 8; t++)
		begin
			errorsBefore = totalErrors();
			comparesBefore = chk.compareCount;
			makeClose();
			makeGuards();
			loadBuffer();
			runExpand(word16'(randRange(0, 40)), 0);
			readBack();
			reportTest("close or descending", errorsBefore, comparesBefore);
		end

		for (t = 0; t < 4; t++)
		begin
			errorsBefore = totalErrors();
			comparesBefore = chk.compareCount;
			makeExtreme();
			makeGuards();
			loadBuffer();
			runExpand(word16'(randRange(0, 40)), 0);
			readBack();
			reportTest("saturating extremes", errorsBefore, comparesBefore);
		end

		// Full descending span with patterned guard words
		for (t = 0; t < 2; t++)
		begin
			errorsBefore = totalErrors();
			comparesBefore = chk.compareCount;
			coef = '{16'sh7fff, 16'sh4000, 16'sh0000, -16'sh4000, 16'sh8000};
			guardBelow = t ? 32'h0000_7fff : 32'hffff_8000;
			guardAbove = ~guardBelow;
			loadBuffer();
			runExpand(16'sd40, 0);
			readBack();
			reportTest("guard words", errorsBefore, comparesBefore);
		end

		for (t = 0; t < 2; t++)
		begin
			errorsBefore = totalErrors();
			comparesBefore = chk.compareCount;
			makeClose();
			makeGuards();
			loadBuffer();
			runExpand(word16'(randRange(0, 40)), 5);
			// Any second done shows up here
			repeat (30) @(negedge clk);
			readBack();
			reportTest("start during run", errorsBefore, comparesBefore);
		end

		$display("Summary: %0d tests passed, %0d tests failed, %0d errors",
			testsPassed, testsFailed, totalErrors());
		if (testsFailed == 0 && totalErrors() == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- files.f
+incdir+design
design/lspExpandPkg.sv
design/lspBasicOps.sv
design/scratchMemory.sv
design/lspExpandFsm.sv
design/lspExpandPipe.sv
test/lspExpandChecker.sv
test/lspExpand_asserts.sv
test/lspExpandTb.sv
